//--- project.f
src/jag_mem_pkg.sv
src/jag_host_pkg.sv
src/cart_loader.sv
src/boot_rom.sv
src/backup_ram.sv
src/backup_sequencer.sv
src/jag_host_glue.sv
verification/tb_jag_host_glue.sv

//--- verification/tb_jag_host_glue.sv
module tb_jag_host_glue;
	timeunit 1ns;
	timeprecision 1ps;

	typedef enum logic [2:0] {
		OP_BIOS_WR, OP_BIOS_RD, OP_CART, OP_CORE, OP_BK_LOAD, OP_BK_SAVE
	} op_t;

	// one stimulus step whose exp depends on op
	typedef struct packed {
		op_t         op;
		logic [7:0]  idx;  // download index or cksum_patch for bios reads
		logic [24:0] addr;
		logic [15:0] data;
		logic [15:0] exp;
	} row_t;

	localparam int N_ROWS = 18;
	localparam row_t ROWS [N_ROWS] = '{
		'{OP_BIOS_WR, 8'd0, 25'h00000, 16'h1234, 16'h0000},
		'{OP_BIOS_WR, 8'd0, 25'h00002, 16'habcd, 16'h0000},
		'{OP_BIOS_WR, 8'd0, 25'h0136E, 16'h5aa5, 16'h0000},
		'{OP_BIOS_RD, 8'd0, 25'h00000, 16'h0000, 16'h0034}, // low byte even
		'{OP_BIOS_RD, 8'd0, 25'h00001, 16'h0000, 16'h0012}, // high byte odd
		'{OP_BIOS_RD, 8'd1, 25'h00003, 16'h0000, 16'h00ab},
		'{OP_BIOS_RD, 8'd1, 25'h0136E, 16'h0000, 16'h0060}, // patched
		'{OP_BIOS_RD, 8'd0, 25'h0136E, 16'h0000, 16'h00a5}, // unpatched
		'{OP_BIOS_RD, 8'd1, 25'h0136F, 16'h0000, 16'h005a},
		'{OP_CART,    8'd1, 25'h00000, 16'h1122, 16'h00c0}, // exp is be
		'{OP_CART,    8'd1, 25'h00002, 16'h3344, 16'h0030},
		'{OP_CART,    8'd1, 25'h00004, 16'h5566, 16'h000c},
		'{OP_CART,    8'd1, 25'h00006, 16'h7788, 16'h0003},
		'{OP_CART,    8'd1, 25'h00008, 16'h99aa, 16'h00c0}, // next 64-bit word
		'{OP_BK_LOAD, 8'd0, 25'h00000, 16'h0000, 16'h0000}, // exp is led after
		'{OP_CORE,    8'd0, 25'h00005, 16'hbeef, 16'h0001}, // exp is pending
		'{OP_CORE,    8'd0, 25'h003ff, 16'h0f0f, 16'h0001},
		'{OP_BK_SAVE, 8'd0, 25'h00000, 16'h0000, 16'h0000}
	};

	logic                    clk_sys;
	logic                    reset;
	jag_host_pkg::ioctl_t    host;
	logic                    mem_ack;
	jag_host_pkg::sd_buf_t   sd_buf;
	logic                    img_mounted;
	logic                    img_readonly;
	logic                    osd_status;
	logic                    bk_load;
	logic                    bk_save;
	logic                    autosave;
	logic                    cksum_patch;
	jag_mem_pkg::bios_addr_t bios_addr;
	jag_mem_pkg::bram_addr_t bram_addr;
	jag_mem_pkg::half_word_t bram_data;
	logic                    bram_wr;
	jag_mem_pkg::mem_wr_t    mem_wr;
	logic                    host_wait;
	jag_host_pkg::sd_req_t   sd_req;
	jag_mem_pkg::half_word_t sd_buff_din;
	logic [7:0]              bios_q;
	jag_mem_pkg::half_word_t bram_q;
	logic                    console_reset;
	logic                    led;

	jag_mem_pkg::half_word_t ram_model [1024]; // backup ram as the host sees it
	jag_mem_pkg::cart_addr_t cart_addr;        // expected loader byte address
	int                      cycles;
	int                      cycle_limit;

	jag_host_glue i_dut (.*);

	always #50 clk_sys = ~clk_sys; // 100 ns period

	// ==================================================
	// run limit
	// ==================================================
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Errors found");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("error: %s got %h expected %h", name, got, exp);
			$display("Errors found");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	function automatic int row_budget(input op_t op);
		case (op)
			OP_BK_LOAD: return 4 * 262 + 1040; // sectors plus bram readback
			OP_BK_SAVE: return 4 * 262 + 10;
			default:    return 8;
		endcase
	endfunction

	task automatic begin_download(input logic [7:0] idx);
		@(posedge clk_sys);
		host.download <= 1'b1;
		host.index    <= idx;
		repeat (2) @(posedge clk_sys); // loader sees the edge
		@(negedge clk_sys);
		check("console_reset", console_reset, 1'b1);
		check("led", led, 1'b1);
	endtask

	task automatic end_download(input logic led_exp);
		@(posedge clk_sys);
		host.download <= 1'b0;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check("console_reset", console_reset, 1'b0);
		check("led", led, led_exp);
	endtask

	task automatic host_word(input logic [24:0] addr, input logic [15:0] data);
		@(posedge clk_sys);
		host.wr   <= 1'b1;
		host.addr <= addr;
		host.data <= data;
		@(posedge clk_sys);
		host.wr <= 1'b0;
	endtask

	task automatic bios_read(input logic patch, input logic [24:0] addr, input logic [7:0] exp);
		@(posedge clk_sys);
		bios_addr   <= addr[16:0];
		cksum_patch <= patch;
		@(posedge clk_sys);
		@(negedge clk_sys); // one cycle of read latency
		check("bios_q", bios_q, exp);
	endtask

	task automatic cart_word(input logic [15:0] data, input logic [7:0] be_exp);
		host_word(25'h0, data); // loader ignores host addr
		@(negedge clk_sys);
		check("mem_wr.we", mem_wr.we, 1'b1);
		check("mem_wr.addr", mem_wr.addr, {1'b0, jag_mem_pkg::DDR_REGION, cart_addr[23:3]});
		check("mem_wr.be", mem_wr.be, be_exp);
		check("mem_wr.data", mem_wr.data, {4{data[7:0], data[15:8]}});
		check("host_wait", host_wait, 1'b0);
		check("led", led, 1'b1);
		cart_addr = cart_addr + 32'd2;
		@(posedge clk_sys);
		mem_ack <= 1'b0; // memory busy for one cycle
		@(negedge clk_sys);
		check("host_wait", host_wait, 1'b1);
		@(posedge clk_sys);
		mem_ack <= 1'b1;
	endtask

	task automatic core_write(input logic [24:0] addr, input logic [15:0] data, input logic exp);
		@(posedge clk_sys);
		bram_addr <= addr[9:0];
		bram_data <= data;
		bram_wr   <= 1'b1;
		@(posedge clk_sys);
		bram_wr <= 1'b0;
		@(negedge clk_sys);
		ram_model[addr[9:0]] = data;
		check("pending", pending_of(), exp);
		check("led", led, 1'b1);
	endtask

	function automatic logic pending_of();
		return i_dut.pending;
	endfunction

	// ==================================================
	// host sector model
	// ==================================================
	task automatic serve_backup(input logic is_load, input logic led_exp);
		jag_mem_pkg::half_word_t w;
		for (int s = 0; s < 4; s++) begin
			@(negedge clk_sys);
			while (!(sd_req.rd || sd_req.wr))
				@(negedge clk_sys);
			check("sd_req.rd", sd_req.rd, is_load);
			check("sd_req.wr", sd_req.wr, !is_load);
			check("sd_req.lba", sd_req.lba, s);
			@(posedge clk_sys);
			sd_buf.ack       <= 1'b1;
			sd_buf.buff_addr <= 8'd0;
			if (is_load) begin
				for (int i = 0; i < 256; i++) begin
					w = jag_mem_pkg::half_word_t'($urandom());
					ram_model[s * 256 + i] = w; // kept for the readback
					@(posedge clk_sys);
					sd_buf.buff_addr <= i[7:0];
					sd_buf.buff_dout <= w;
					sd_buf.buff_wr   <= 1'b1;
				end
			end else begin
				for (int i = 1; i <= 256; i++) begin
					@(posedge clk_sys);
					if (i < 256)
						sd_buf.buff_addr <= i[7:0];
					@(negedge clk_sys); // din lags addr by one
					check("sd_buff_din", sd_buff_din, ram_model[s * 256 + i - 1]);
				end
			end
			@(posedge clk_sys);
			sd_buf.buff_wr <= 1'b0;
			sd_buf.ack     <= 1'b0; // falling ack ends the sector
		end
		@(negedge clk_sys);
		while (i_dut.busy)
			@(negedge clk_sys);
		check("sd_req.lba", sd_req.lba, 32'd0);
		check("sd_req.rd", sd_req.rd, 1'b0);
		check("sd_req.wr", sd_req.wr, 1'b0);
		check("pending", pending_of(), 1'b0);
		check("led", led, led_exp);
	endtask

	task automatic verify_bram();
		for (int a = 0; a <= 1024; a++) begin
			@(posedge clk_sys);
			if (a < 1024)
				bram_addr <= jag_mem_pkg::bram_addr_t'(a);
			@(negedge clk_sys);
			if (a > 0)
				check("bram_q", bram_q, ram_model[a - 1]);
		end
	endtask

	// ==================================================
	// main sequence
	// ==================================================
	initial begin
		void'($urandom(86480));
		clk_sys      = 1'b0;
		reset        = 1'b1;
		host         = '0;
		mem_ack      = 1'b1; // memory ready by default
		sd_buf       = '0;
		img_mounted  = 1'b1;
		img_readonly = 1'b0;
		osd_status   = 1'b0;
		bk_load      = 1'b0;
		bk_save      = 1'b0;
		autosave     = 1'b0;
		cksum_patch  = 1'b0;
		bios_addr    = '0;
		bram_addr    = '0;
		bram_data    = '0;
		bram_wr      = 1'b0;
		cart_addr    = jag_mem_pkg::CART_BASE;
		cycles       = 0;
		cycle_limit  = 10;
		for (int r = 0; r < N_ROWS; r++)
			cycle_limit += row_budget(ROWS[r].op);
		cycle_limit *= 4;

		repeat (10) @(posedge clk_sys);
		reset <= 1'b0;

		for (int r = 0; r < N_ROWS; r++) begin
			case (ROWS[r].op)
				OP_BIOS_WR: begin
					if (!host.download)
						begin_download(ROWS[r].idx);
					host_word(ROWS[r].addr, ROWS[r].data);
					repeat (2) @(posedge clk_sys); // both bytes land
				end
				OP_BIOS_RD: begin
					if (host.download)
						end_download(1'b0);
					bios_read(ROWS[r].idx[0], ROWS[r].addr, ROWS[r].exp[7:0]);
				end
				OP_CART: begin
					if (!host.download)
						begin_download(ROWS[r].idx);
					cart_word(ROWS[r].data, ROWS[r].exp[7:0]);
				end
				OP_CORE: core_write(ROWS[r].addr, ROWS[r].data, ROWS[r].exp[0]);
				OP_BK_LOAD: begin
					end_download(1'b1); // end of cart starts the load
					serve_backup(1'b1, ROWS[r].exp[0]);
					verify_bram();
				end
				OP_BK_SAVE: begin
					@(posedge clk_sys);
					osd_status <= 1'b1;
					autosave   <= 1'b1;
					bk_save    <= 1'b1;
					serve_backup(1'b0, ROWS[r].exp[0]);
					@(posedge clk_sys);
					bk_save    <= 1'b0;
					osd_status <= 1'b0;
				end
			endcase
		end

		$display("No errors");
		$finish;
	end

endmodule

//--- src/jag_host_glue.sv
module jag_host_glue (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  jag_host_pkg::ioctl_t    host,
	input  logic                    mem_ack,
	input  jag_host_pkg::sd_buf_t   sd_buf,
	input  logic                    img_mounted,
	input  logic                    img_readonly,
	input  logic                    osd_status,
	input  logic                    bk_load,
	input  logic                    bk_save,
	input  logic                    autosave,
	input  logic                    cksum_patch,
	input  jag_mem_pkg::bios_addr_t bios_addr,
	input  jag_mem_pkg::bram_addr_t bram_addr,
	input  jag_mem_pkg::half_word_t bram_data,
	input  logic                    bram_wr,
	output jag_mem_pkg::mem_wr_t    mem_wr,
	output logic                    host_wait,
	output jag_host_pkg::sd_req_t   sd_req,
	output jag_mem_pkg::half_word_t sd_buff_din,
	output logic [7:0]              bios_q,
	output jag_mem_pkg::half_word_t bram_q,
	output logic                    console_reset,
	output logic                    led
);

	logic busy;    // backup transfer running
	logic pending; // unsaved console writes

	// ==================================================
	// host image paths
	// ==================================================
	cart_loader i_cart_loader (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.host         (host),
		.mem_ack      (mem_ack),
		.mem_wr       (mem_wr),
		.host_wait    (host_wait),
		.cart_loading ()          // only checked inside the loader
	);

	boot_rom i_boot_rom (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.host        (host),
		.cksum_patch (cksum_patch),
		.bios_addr   (bios_addr),
		.bios_q      (bios_q)
	);

	// ==================================================
	// backup ram and its sector traffic
	// ==================================================
	backup_ram i_backup_ram (
		.clk_sys     (clk_sys),
		.bram_addr   (bram_addr),
		.bram_data   (bram_data),
		.bram_wr     (bram_wr),
		.sd_lba      (sd_req.lba),
		.sd_buf      (sd_buf),
		.bram_q      (bram_q),
		.sd_buff_din (sd_buff_din)
	);

	backup_sequencer i_backup_sequencer (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.host         (host),
		.sd_ack       (sd_buf.ack),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.osd_status   (osd_status),
		.bk_load      (bk_load),
		.bk_save      (bk_save),
		.autosave     (autosave),
		.bram_wr      (bram_wr),
		.sd_req       (sd_req),
		.busy         (busy),
		.pending      (pending)
	);

	assign console_reset = reset | host.download;   // console held during any download
	assign led           = host.download | busy | pending;

endmodule

//--- src/backup_sequencer.sv
module backup_sequencer (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  jag_host_pkg::ioctl_t  host,
	input  logic                  sd_ack,
	input  logic                  img_mounted,
	input  logic                  img_readonly,
	input  logic                  osd_status,
	input  logic                  bk_load,
	input  logic                  bk_save,
	input  logic                  autosave,
	input  logic                  bram_wr,
	output jag_host_pkg::sd_req_t sd_req,
	output logic                  busy,
	output logic                  pending
);

	typedef enum logic {
		ST_IDLE,
		ST_XFER // four sectors in flight
	} bk_state_t;

	bk_state_t state;
	logic      cart_dl;
	logic      old_dl;
	logic      bk_ena;   // save file mounted and writable
	logic      loading;  // direction of the running transfer
	logic      auto_req; // menu closed with unsaved data
	logic      old_load;
	logic      old_save;
	logic      old_auto;
	logic      old_ack;
	logic      start;

	assign cart_dl  = host.download && host.index[5:0] == jag_host_pkg::IDX_CART;
	assign auto_req = pending & osd_status & autosave;
	assign start    = (bk_load & ~old_load) | (bk_save & ~old_save) | (auto_req & ~old_auto);
	assign busy     = state == ST_XFER;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state      <= ST_IDLE;
			loading    <= 1'b0;
			bk_ena     <= 1'b0;
			pending    <= 1'b0;
			sd_req.rd  <= 1'b0;
			sd_req.wr  <= 1'b0;
			sd_req.lba <= '0;
			old_dl     <= 1'b0;
			old_load   <= 1'b0;
			old_save   <= 1'b0;
			old_auto   <= 1'b0;
			old_ack    <= 1'b0;
		end else begin
			old_dl   <= cart_dl;
			old_load <= bk_load;
			old_save <= bk_save;
			old_auto <= auto_req;
			old_ack  <= sd_ack;

			// save file comes mounted during the cart download
			if (!old_dl && cart_dl)
				bk_ena <= 1'b0;
			if (cart_dl && img_mounted && !img_readonly)
				bk_ena <= 1'b1;

			if (bk_ena && !osd_status && bram_wr)
				pending <= 1'b1;
			else if (busy)
				pending <= 1'b0;

			// host took the request
			if (!old_ack && sd_ack) begin
				sd_req.rd <= 1'b0;
				sd_req.wr <= 1'b0;
			end

			case (state)
				ST_IDLE: begin
					if (bk_ena && start) begin
						state      <= ST_XFER;
						loading    <= bk_load & ~old_load; // load wins a tie
						sd_req.lba <= '0;
						sd_req.rd  <= bk_load & ~old_load;
						sd_req.wr  <= ~(bk_load & ~old_load);
					end
					// end of cart download pulls in its save
					if (bk_ena && old_dl && !cart_dl) begin
						state      <= ST_XFER;
						loading    <= 1'b1;
						sd_req.lba <= '0;
						sd_req.rd  <= 1'b1;
						sd_req.wr  <= 1'b0;
					end
				end
				ST_XFER: begin
					if (old_ack && !sd_ack) begin // sector done
						if (sd_req.lba == jag_host_pkg::BK_SECTORS - 32'd1) begin
							state      <= ST_IDLE;
							loading    <= 1'b0;
							sd_req.lba <= '0;
						end else begin
							sd_req.lba <= sd_req.lba + 32'd1;
							sd_req.rd  <= loading;
							sd_req.wr  <= ~loading;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// requests only inside a transfer and in its direction
	a_req_in_xfer: assert property (@(posedge clk_sys) disable iff (reset)
		(sd_req.rd || sd_req.wr) |-> busy && loading == sd_req.rd && sd_req.rd != sd_req.wr)
		else $error("sector request outside a transfer or with rd and wr together");

endmodule

//--- src/backup_ram.sv
module backup_ram (
	input  logic                    clk_sys,
	input  jag_mem_pkg::bram_addr_t bram_addr,
	input  jag_mem_pkg::half_word_t bram_data,
	input  logic                    bram_wr,
	input  logic [31:0]             sd_lba,
	input  jag_host_pkg::sd_buf_t   sd_buf,
	output jag_mem_pkg::half_word_t bram_q,
	output jag_mem_pkg::half_word_t sd_buff_din
);

	jag_mem_pkg::half_word_t ram [2**$bits(jag_mem_pkg::bram_addr_t)];

	logic                    in_range; // lba inside the backup image
	jag_mem_pkg::bram_addr_t addr_b;
	logic                    we_b;

	assign in_range = sd_lba < jag_host_pkg::BK_SECTORS;
	assign addr_b   = {sd_lba[1:0], sd_buf.buff_addr}; // sector picks the quarter
	assign we_b     = sd_buf.ack & sd_buf.buff_wr & in_range;

	// port a, console side
	always @(posedge clk_sys) begin
		if (bram_wr)
			ram[bram_addr] <= bram_data;
		bram_q <= ram[bram_addr];
	end

	// port b, host sector buffer
	always @(posedge clk_sys) begin
		if (we_b)
			ram[addr_b] <= sd_buf.buff_dout;
		sd_buff_din <= ram[addr_b]; // one cycle after buff_addr
	end

endmodule

//--- src/boot_rom.sv
module boot_rom (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  jag_host_pkg::ioctl_t    host,
	input  logic                    cksum_patch,
	input  jag_mem_pkg::bios_addr_t bios_addr,
	output logic [7:0]              bios_q
);

	logic [7:0] rom_mem [2**$bits(jag_mem_pkg::bios_addr_t)];

	logic                    bios_dl;
	logic                    wr_lo;    // low byte cycle
	logic                    wr_hi;    // high byte cycle
	logic                    wren;
	logic [15:0]             wa_q;     // host word address
	jag_mem_pkg::half_word_t wd_q;
	jag_mem_pkg::bios_addr_t wr_addr;
	logic [7:0]              wr_byte;
	jag_mem_pkg::bios_addr_t rd_addr_q;
	logic [7:0]              rd_q;

	// either bios slot loads the same rom
	assign bios_dl = host.download &&
		(host.index[5:0] == jag_host_pkg::IDX_BIOS_A ||
		 host.index[5:0] == jag_host_pkg::IDX_BIOS_B);

	// ==================================================
	// host word split into two byte writes
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_lo <= 1'b0;
			wr_hi <= 1'b0;
		end else begin
			wr_lo <= host.wr & bios_dl;
			wr_hi <= wr_lo; // high byte follows
		end
	end

	always_ff @(posedge clk_sys) begin
		if (host.wr && bios_dl) begin
			wa_q <= host.addr[16:1];
			wd_q <= host.data;
		end
	end

	assign wren    = wr_lo | wr_hi;
	assign wr_addr = {wa_q, wr_hi};                       // even then odd
	assign wr_byte = wr_hi ? wd_q[15:8] : wd_q[7:0];

	// ==================================================
	// storage, synchronous read
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (wren)
			rom_mem[wr_addr] <= wr_byte;
		rd_addr_q <= bios_addr;
		rd_q      <= rom_mem[bios_addr];
	end

	// beq to bra, skips the cart checksum fail path
	assign bios_q = (cksum_patch && rd_addr_q == jag_mem_pkg::PATCH_ADDR) ?
		jag_mem_pkg::PATCH_BYTE : rd_q;

	// two bytes per host word and no more
	a_two_byte_wr: assert property (@(posedge clk_sys) disable iff (reset)
		wren ##1 wren |=> !wren)
		else $error("bios write strobe longer than two cycles");

endmodule

//--- src/cart_loader.sv
module cart_loader (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  jag_host_pkg::ioctl_t host,
	input  logic                 mem_ack,
	output jag_mem_pkg::mem_wr_t mem_wr,
	output logic                 host_wait,
	output logic                 cart_loading
);

	logic                    cart_idx;
	logic                    old_download;
	logic                    loader_wr;   // write strobe, one cycle after host wr
	jag_mem_pkg::cart_addr_t loader_addr; // running byte address
	jag_mem_pkg::half_word_t word_q;
	jag_mem_pkg::half_word_t word_bs;
	jag_mem_pkg::byte_en_t   be;

	assign cart_idx = host.index[5:0] == jag_host_pkg::IDX_CART;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_download <= 1'b0;
			loader_wr    <= 1'b0;
			cart_loading <= 1'b0;
			loader_addr  <= jag_mem_pkg::CART_BASE;
		end else begin
			old_download <= host.download;
			loader_wr    <= host.wr & host.download & cart_idx;
			if (loader_wr)
				loader_addr <= loader_addr + 32'd2; // 16-bit word per strobe
			// start of a cart image, restart at the cart window
			if (!old_download && host.download && cart_idx) begin
				loader_addr  <= jag_mem_pkg::CART_BASE;
				cart_loading <= 1'b1;
			end
			if (old_download && !host.download)
				cart_loading <= 1'b0;
		end
	end

	// word captured at the host strobe
	always_ff @(posedge clk_sys) begin
		if (host.wr && cart_idx)
			word_q <= host.data;
	end

	// lane select from the word position inside the 64-bit word
	always_comb begin
		case (loader_addr[2:1])
			2'd0:    be = 8'b1100_0000;
			2'd1:    be = 8'b0011_0000;
			2'd2:    be = 8'b0000_1100;
			default: be = 8'b0000_0011;
		endcase
	end

	assign word_bs = {word_q[7:0], word_q[15:8]}; // image is byte swapped

	always_comb begin
		mem_wr.we   = loader_wr;
		mem_wr.addr = {1'b0, jag_mem_pkg::DDR_REGION, loader_addr[23:3]}; // top bit unused
		mem_wr.be   = be;
		mem_wr.data = {4{word_bs}}; // be picks the lane
	end

	assign host_wait = ~mem_ack; // hold the host until memory takes the word

	// strobes only inside a cart load window
	a_we_in_load: assert property (@(posedge clk_sys) disable iff (reset)
		mem_wr.we |-> cart_loading)
		else $error("cart write outside of a cart load");

endmodule

//--- src/jag_host_pkg.sv
package jag_host_pkg;

	// ==================================================
	// host download link
	// ==================================================
	typedef struct packed {
		logic        download; // high for the whole transfer
		logic        wr;       // one word per pulse
		logic [7:0]  index;    // menu slot, low 6 bits compared
		logic [24:0] addr;     // byte address in the image
		logic [15:0] data;
	} ioctl_t;

	// download slots, bits 5..0 of index
	localparam logic [5:0] IDX_BIOS_A = 6'd0;
	localparam logic [5:0] IDX_CART   = 6'd1;
	localparam logic [5:0] IDX_BIOS_B = 6'd2; // bios from the menu entry

	// ==================================================
	// host sector access
	// ==================================================
	typedef struct packed {
		logic        rd;
		logic        wr;
		logic [31:0] lba;
	} sd_req_t;

	typedef struct packed {
		logic        ack;       // high while the host serves a sector
		logic [7:0]  buff_addr; // word inside the sector
		logic [15:0] buff_dout; // host to core
		logic        buff_wr;
	} sd_buf_t;

	localparam logic [31:0] BK_SECTORS = 32'd4; // one backup image

endpackage

//--- src/jag_mem_pkg.sv
package jag_mem_pkg;

	// ==================================================
	// widths that carry a meaning
	// ==================================================
	typedef logic [28:0] ddr_addr_t;  // ext memory, 64-bit word address
	typedef logic [31:0] cart_addr_t; // loader byte address
	typedef logic [7:0]  byte_en_t;   // one bit per byte lane
	typedef logic [63:0] mem_word_t;
	typedef logic [16:0] bios_addr_t; // 128 KiB boot rom, byte wide
	typedef logic [9:0]  bram_addr_t; // 4 sectors of 256 words
	typedef logic [15:0] half_word_t;

	// ==================================================
	// memory map
	// ==================================================
	localparam cart_addr_t CART_BASE  = 32'h0080_0000; // cart window of the console
	localparam logic [6:0] DDR_REGION = 7'b0110000;    // console area in ext memory

	// checksum skip patch
	localparam bios_addr_t PATCH_ADDR = 17'h0136E; // beq after the cart checksum
	localparam logic [7:0] PATCH_BYTE = 8'h60;     // bra opcode

	// ext memory write port, one strobe per word
	typedef struct packed {
		logic      we;
		ddr_addr_t addr;
		byte_en_t  be;
		mem_word_t data;
	} mem_wr_t;

endpackage
